// File: hw/wbuf_pkg.sv
package wbuf_pkg;

    localparam int DEF_SLOTS = 4;
    localparam int SLOT_W = $clog2(DEF_SLOTS);

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] strb_t;
    typedef logic src_t;

    localparam src_t SRC_LINE = 1'b0; // cache line writeback
    localparam src_t SRC_UNC = 1'b1; // uncached store

    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [7:0] LEN_SINGLE = 8'd0;
    localparam strb_t STRB_ALL = 4'hf;

    typedef struct packed {
        src_t src;
        logic [SLOT_W-1:0] slot;
        addr_t addr;
        logic [7:0] len; // beats minus one
        strb_t strb;
    } wbuf_entry_t;

endpackage

// File: hw/wbuf_slot_alloc.sv
`timescale 1ns/1ps

module wbuf_slot_alloc import wbuf_pkg::*; #(
    parameter int SLOTS = 4
) (
    input logic i_clk,
    input logic i_rst,
    input logic i_line_we,
    input logic i_unc_we,
    input logic i_free,
    input src_t i_free_src,
    input logic [$clog2(SLOTS)-1:0] i_free_slot,
    output logic [$clog2(SLOTS)-1:0] o_line_slot,
    output logic [$clog2(SLOTS)-1:0] o_unc_slot,
    output logic o_line_free,
    output logic o_unc_full
);

    localparam int SW = $clog2(SLOTS);
    localparam int CW = $clog2(SLOTS + 1);

    logic [SLOTS-1:0] line_busy;
    logic [SLOTS-1:0] unc_busy;
    logic [CW-1:0] unc_cnt;
    logic free_unc;

    function automatic logic [SW-1:0] lowest_free(input logic [SLOTS-1:0] busy);
        logic [SW-1:0] idx;
        idx = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) idx = SW'(i); // lowest clear bit wins
        end
        return idx;
    endfunction

    assign o_line_slot = lowest_free(line_busy);
    assign o_unc_slot = lowest_free(unc_busy);
    assign o_line_free = ~&line_busy;
    assign o_unc_full = unc_cnt >= CW'(SLOTS - 1);
    assign free_unc = i_free && (i_free_src == SRC_UNC);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            line_busy <= '0;
            unc_busy <= '0;
            unc_cnt <= '0;
        end else begin
            // alloc and free never hit the same slot
            if (i_line_we) line_busy[o_line_slot] <= 1'b1;
            if (i_unc_we) unc_busy[o_unc_slot] <= 1'b1;
            if (i_free && i_free_src == SRC_LINE) line_busy[i_free_slot] <= 1'b0;
            if (free_unc) unc_busy[i_free_slot] <= 1'b0;
            case ({i_unc_we, free_unc})
                2'b10: unc_cnt <= unc_cnt + 1'b1;
                2'b01: unc_cnt <= unc_cnt - 1'b1;
                default: unc_cnt <= unc_cnt;
            endcase
        end
    end

endmodule

// File: hw/wbuf_queue.sv
`timescale 1ns/1ps

module wbuf_queue import wbuf_pkg::*; #(
    parameter int DEPTH = 8
) (
    input logic i_clk,
    input logic i_rst,
    input logic i_push_a,
    input wbuf_entry_t i_entry_a,
    input logic i_push_b,
    input wbuf_entry_t i_entry_b,
    input logic i_pop,
    output wbuf_entry_t o_head,
    output logic o_empty
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    wbuf_entry_t mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [PW-1:0] wr_ptr_b;
    logic do_pop;

    function automatic logic [PW-1:0] ptr_add(input logic [PW-1:0] ptr, input int n);
        int sum;
        sum = int'(ptr) + n;
        if (sum >= DEPTH) sum = sum - DEPTH; // wrap for any depth
        return PW'(sum);
    endfunction

    assign wr_ptr_b = ptr_add(wr_ptr, int'(i_push_a)); // b lands after a
    assign do_pop = i_pop && !o_empty;
    assign o_head = mem[rd_ptr];
    assign o_empty = (count == '0);

    always_ff @(posedge i_clk) begin
        if (i_push_a) mem[wr_ptr] <= i_entry_a;
        if (i_push_b) mem[wr_ptr_b] <= i_entry_b;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, int'(i_push_a) + int'(i_push_b));
            if (do_pop) rd_ptr <= ptr_add(rd_ptr, 1);
            count <= count + CW'(i_push_a) + CW'(i_push_b) - CW'(do_pop);
        end
    end

endmodule

// File: hw/wbuf_line_store.sv
`timescale 1ns/1ps

module wbuf_line_store import wbuf_pkg::*; #(
    parameter int SLOTS = 4,
    parameter int LINE_WORDS = 8
) (
    input logic i_clk,
    input logic i_line_we,
    input logic [$clog2(SLOTS)-1:0] i_line_slot,
    input word_t [LINE_WORDS-1:0] i_line_data,
    input logic i_unc_we,
    input logic [$clog2(SLOTS)-1:0] i_unc_slot,
    input word_t i_unc_data,
    input src_t i_rd_src,
    input logic [$clog2(SLOTS)-1:0] i_rd_slot,
    input logic [$clog2(LINE_WORDS)-1:0] i_rd_beat,
    output word_t o_rd_data
);

    word_t line_mem [SLOTS][LINE_WORDS];
    word_t unc_mem [SLOTS];

    always_ff @(posedge i_clk) begin
        if (i_line_we) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                line_mem[i_line_slot][w] <= i_line_data[w]; // whole line at once
            end
        end
        if (i_unc_we) unc_mem[i_unc_slot] <= i_unc_data;
    end

    always_comb begin
        if (i_rd_src == SRC_UNC) begin
            o_rd_data = unc_mem[i_rd_slot]; // single beat, word zero
        end else begin
            o_rd_data = line_mem[i_rd_slot][i_rd_beat];
        end
    end

endmodule

// File: hw/wbuf_beat_counter.sv
`timescale 1ns/1ps

module wbuf_beat_counter #(
    parameter int LINE_WORDS = 8
) (
    input logic i_clk,
    input logic i_rst,
    input logic i_clear,
    input logic i_step,
    input logic [7:0] i_len,
    output logic [$clog2(LINE_WORDS)-1:0] o_beat,
    output logic o_last
);

    localparam int BW = $clog2(LINE_WORDS);

    assign o_last = ({{(8 - BW){1'b0}}, o_beat} == i_len);

    always_ff @(posedge i_clk) begin
        if (i_rst || i_clear) begin
            o_beat <= '0;
        end else if (i_step) begin
            o_beat <= o_beat + 1'b1; // one per accepted beat
        end
    end

endmodule

// File: hw/wbuf_axi_fsm.sv
`timescale 1ns/1ps

module wbuf_axi_fsm import wbuf_pkg::*; (
    input logic i_clk,
    input logic i_rst,
    input logic i_empty,
    input wbuf_entry_t i_head,
    input logic i_last,
    input logic i_awready,
    input logic i_wready,
    input logic i_bvalid,
    output logic o_awvalid,
    output logic o_wvalid,
    output logic o_bready,
    output logic o_beat_clear,
    output logic o_beat_step,
    output logic o_pop,
    output logic o_line_start,
    output logic o_unc_start,
    output logic o_line_end,
    output logic o_unc_end,
    output logic o_busy
);

    typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} state_t;

    state_t state;
    state_t state_nxt;
    logic aw_fire;
    logic is_unc;

    assign is_unc = (i_head.src == SRC_UNC);
    assign o_awvalid = (state == ADDR);
    assign o_wvalid = (state == DATA);
    assign o_bready = 1'b1;
    assign o_busy = (state != IDLE);

    assign aw_fire = o_awvalid && i_awready;
    assign o_beat_clear = aw_fire; // counter starts fresh each burst
    assign o_beat_step = o_wvalid && i_wready;
    assign o_pop = (state == RESP) && i_bvalid; // also frees the slot

    assign o_line_start = aw_fire && !is_unc;
    assign o_unc_start = aw_fire && is_unc;
    assign o_line_end = o_pop && !is_unc;
    assign o_unc_end = o_pop && is_unc;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (!i_empty) state_nxt = ADDR;
            ADDR: if (i_awready) state_nxt = DATA;
            DATA: if (i_wready && i_last) state_nxt = RESP;
            RESP: if (i_bvalid) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) state <= IDLE;
        else state <= state_nxt;
    end

endmodule

// File: hw/wbuf_top.sv
`timescale 1ns/1ps

module wbuf_top import wbuf_pkg::*; #(
    parameter int SLOTS = 4,
    parameter int LINE_WORDS = 8
) (
    input logic i_clk,
    input logic i_rst,
    input logic i_line_we,
    input addr_t i_line_addr,
    input word_t [LINE_WORDS-1:0] i_line_data,
    output logic [$clog2(SLOTS)-1:0] o_line_slot,
    output logic o_line_free,
    output logic o_line_start,
    output logic o_line_end,
    input logic i_unc_we,
    input addr_t i_unc_addr,
    input word_t i_unc_data,
    input strb_t i_unc_strb,
    output logic [$clog2(SLOTS)-1:0] o_unc_slot,
    output logic o_unc_full,
    output logic o_unc_start,
    output logic o_unc_end,
    output logic o_empty,
    output logic o_busy,
    output addr_t o_awaddr,
    output logic [7:0] o_awlen,
    output logic [1:0] o_awburst,
    output logic o_awvalid,
    input logic i_awready,
    output word_t o_wdata,
    output strb_t o_wstrb,
    output logic o_wlast,
    output logic o_wvalid,
    input logic i_wready,
    input logic i_bvalid,
    output logic o_bready
);

    wbuf_entry_t line_entry;
    wbuf_entry_t unc_entry;
    wbuf_entry_t head;
    logic pop;
    logic beat_clear;
    logic beat_step;
    logic beat_last;
    logic [$clog2(LINE_WORDS)-1:0] beat;

    assign line_entry = '{src: SRC_LINE, slot: o_line_slot, addr: i_line_addr,
                          len: 8'(LINE_WORDS - 1), strb: STRB_ALL};
    assign unc_entry = '{src: SRC_UNC, slot: o_unc_slot, addr: i_unc_addr,
                         len: LEN_SINGLE, strb: i_unc_strb};

    assign o_awaddr = head.addr;
    assign o_awlen = head.len;
    assign o_awburst = BURST_INCR;
    assign o_wstrb = head.strb;
    assign o_wlast = o_wvalid && beat_last;

    wbuf_slot_alloc #(.SLOTS(SLOTS)) u_alloc (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_line_we(i_line_we), .i_unc_we(i_unc_we),
        .i_free(pop), .i_free_src(head.src), .i_free_slot(head.slot),
        .o_line_slot(o_line_slot), .o_unc_slot(o_unc_slot),
        .o_line_free(o_line_free), .o_unc_full(o_unc_full)
    );

    // uncached on port a so a same-cycle pair queues it first
    wbuf_queue #(.DEPTH(2 * SLOTS)) u_queue (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_push_a(i_unc_we), .i_entry_a(unc_entry),
        .i_push_b(i_line_we), .i_entry_b(line_entry),
        .i_pop(pop), .o_head(head), .o_empty(o_empty)
    );

    wbuf_line_store #(.SLOTS(SLOTS), .LINE_WORDS(LINE_WORDS)) u_store (
        .i_clk(i_clk),
        .i_line_we(i_line_we), .i_line_slot(o_line_slot), .i_line_data(i_line_data),
        .i_unc_we(i_unc_we), .i_unc_slot(o_unc_slot), .i_unc_data(i_unc_data),
        .i_rd_src(head.src), .i_rd_slot(head.slot), .i_rd_beat(beat),
        .o_rd_data(o_wdata)
    );

    wbuf_beat_counter #(.LINE_WORDS(LINE_WORDS)) u_beat (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_clear(beat_clear), .i_step(beat_step), .i_len(head.len),
        .o_beat(beat), .o_last(beat_last)
    );

    wbuf_axi_fsm u_fsm (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_empty(o_empty), .i_head(head), .i_last(beat_last),
        .i_awready(i_awready), .i_wready(i_wready), .i_bvalid(i_bvalid),
        .o_awvalid(o_awvalid), .o_wvalid(o_wvalid), .o_bready(o_bready),
        .o_beat_clear(beat_clear), .o_beat_step(beat_step), .o_pop(pop),
        .o_line_start(o_line_start), .o_unc_start(o_unc_start),
        .o_line_end(o_line_end), .o_unc_end(o_unc_end),
        .o_busy(o_busy)
    );

endmodule

// File: tb/wbuf_asserts.sv
`timescale 1ns/1ps

module wbuf_asserts import wbuf_pkg::*; (
    input logic i_clk,
    input logic i_rst,
    input logic i_awvalid,
    input logic i_awready,
    input addr_t i_awaddr,
    input logic [7:0] i_awlen,
    input logic i_wvalid,
    input logic i_wready,
    input word_t i_wdata,
    input strb_t i_wstrb,
    input logic i_wlast,
    input logic i_bvalid,
    input logic i_bready,
    input logic i_busy,
    input logic i_empty,
    input logic i_line_free,
    input logic i_unc_full
);

    int fail_cnt = 0; // failed assertions
    logic in_burst; // address accepted, response not yet
    logic [7:0] burst_len;
    logic [7:0] beat_cnt;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_burst <= 1'b0;
            burst_len <= '0;
            beat_cnt <= '0;
        end else begin
            if (i_awvalid && i_awready) begin
                in_burst <= 1'b1;
                burst_len <= i_awlen;
                beat_cnt <= '0;
            end else if (i_wvalid && i_wready) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (i_bvalid && i_bready) in_burst <= 1'b0;
        end
    end

    a_aw_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr) && $stable(i_awlen))
        else begin
            $error("address channel changed while stalled");
            fail_cnt++;
        end

    a_w_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb)
            && $stable(i_wlast))
        else begin
            $error("data channel changed while stalled");
            fail_cnt++;
        end

    // only with wvalid, and only on the beat that completes awlen
    a_wlast: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wlast |-> i_wvalid && beat_cnt == burst_len)
        else begin
            $error("wlast without wvalid or off the last beat");
            fail_cnt++;
        end

    // data and response phases
    a_aw_phase: assert property (@(posedge i_clk) disable iff (i_rst)
        in_burst |-> i_busy && !i_awvalid)
        else begin
            $error("awvalid raised or busy low while a burst is in flight");
            fail_cnt++;
        end

    a_empty_flags: assert property (@(posedge i_clk) disable iff (i_rst)
        i_empty |-> i_line_free && !i_unc_full)
        else begin
            $error("slot flags busy with an empty buffer");
            fail_cnt++;
        end

endmodule

bind wbuf_top wbuf_asserts u_asserts (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_awvalid(o_awvalid), .i_awready(i_awready), .i_awaddr(o_awaddr), .i_awlen(o_awlen),
    .i_wvalid(o_wvalid), .i_wready(i_wready), .i_wdata(o_wdata), .i_wstrb(o_wstrb),
    .i_wlast(o_wlast), .i_bvalid(i_bvalid), .i_bready(o_bready),
    .i_busy(o_busy), .i_empty(o_empty),
    .i_line_free(o_line_free), .i_unc_full(o_unc_full)
);

// File: tb/wbuf_tb.sv
`timescale 1ns/1ps

module wbuf_tb import wbuf_pkg::*; ();

    localparam int SLOTS = 4;
    localparam int LINE_WORDS = 8;
    localparam int SW = $clog2(SLOTS);
    localparam int N_MIX = 12;
    localparam int N_RAND = 30;
    localparam int TOTAL_WR = 4 + 2 * N_MIX + 2 * SLOTS - 1 + 2 * N_RAND; // worst case
    localparam int TIMEOUT_CYC = TOTAL_WR * 40 + 1000;

    typedef struct packed {
        src_t src;
        addr_t addr;
        strb_t strb;
        word_t [LINE_WORDS-1:0] data;
    } wr_t;

    typedef struct packed {
        addr_t addr;
        logic [7:0] len;
        logic [7:0] beats;
        strb_t strb;
        word_t [LINE_WORDS-1:0] words;
    } burst_t;

    logic i_clk = 1'b0;
    logic i_rst = 1'b1;
    logic i_line_we = 1'b0;
    addr_t i_line_addr = '0;
    word_t [LINE_WORDS-1:0] i_line_data = '0;
    logic i_unc_we = 1'b0;
    addr_t i_unc_addr = '0;
    word_t i_unc_data = '0;
    strb_t i_unc_strb = '0;
    logic i_awready = 1'b0;
    logic i_wready = 1'b0;
    logic i_bvalid = 1'b0;
    logic [SW-1:0] o_line_slot;
    logic [SW-1:0] o_unc_slot;
    logic o_line_free;
    logic o_line_start;
    logic o_line_end;
    logic o_unc_full;
    logic o_unc_start;
    logic o_unc_end;
    logic o_empty;
    logic o_busy;
    logic o_awvalid;
    logic o_wlast;
    logic o_wvalid;
    logic o_bready;
    addr_t o_awaddr;
    logic [7:0] o_awlen;
    logic [1:0] o_awburst;
    word_t o_wdata;
    strb_t o_wstrb;

    wr_t exp_q[$];
    burst_t obs_q[$];
    burst_t cur = '0;
    int beats = 0;
    int errors = 0;
    int checks = 0;
    int test_num = 0;
    int errs_before = 0;
    int n_line_wr = 0;
    int n_unc_wr = 0;
    int n_line_start = 0;
    int n_line_end = 0;
    int n_unc_start = 0;
    int n_unc_end = 0;
    logic hold_bus = 1'b0; // keeps awready low
    logic heavy = 1'b0;
    logic b_pend = 1'b0;
    int b_wait = 0;
    logic [31:0] seed = 32'd59545;

    wbuf_top #(.SLOTS(SLOTS), .LINE_WORDS(LINE_WORDS)) wbuf_top_inst (.*);

    initial begin
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // burst the bus should see for one accepted write
    function automatic burst_t expect_burst(input wr_t w);
        burst_t b;
        b = '0;
        b.addr = w.addr;
        if (w.src == SRC_UNC) begin
            b.len = 8'd0;
            b.beats = 8'd1;
            b.strb = w.strb;
            b.words[0] = w.data[0];
        end else begin
            b.len = 8'(LINE_WORDS - 1);
            b.beats = 8'(LINE_WORDS);
            b.strb = 4'hf;
            b.words = w.data;
        end
        return b;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("FAIL %0t %s got %h exp %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic issue(input logic do_line, input logic do_unc);
        wr_t lw;
        wr_t uw;
        logic [31:0] r;
        lw = '0;
        uw = '0;
        r = rand32();
        lw.src = SRC_LINE;
        lw.addr = {r[31:5], 5'b0}; // line aligned
        for (int w = 0; w < LINE_WORDS; w++) lw.data[w] = rand32();
        r = rand32();
        uw.src = SRC_UNC;
        uw.addr = {r[31:2], 2'b0};
        uw.strb = r[3:0];
        uw.data[0] = rand32();
        @(negedge i_clk);
        while ((do_line && !o_line_free) || (do_unc && o_unc_full)) @(negedge i_clk);
        @(posedge i_clk);
        i_line_we <= do_line;
        i_line_addr <= lw.addr;
        i_line_data <= lw.data;
        i_unc_we <= do_unc;
        i_unc_addr <= uw.addr;
        i_unc_data <= uw.data[0];
        i_unc_strb <= uw.strb;
        @(posedge i_clk);
        i_line_we <= 1'b0;
        i_unc_we <= 1'b0;
        if (do_unc) exp_q.push_back(uw); // uncached goes first in a pair
        if (do_line) exp_q.push_back(lw);
        n_line_wr += int'(do_line);
        n_unc_wr += int'(do_unc);
    endtask

    task automatic mixed(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            @(negedge i_clk);
            r = rand32();
            issue(r[1:0] != 2'd1, r[1:0] != 2'd0);
        end
    endtask

    task automatic drain();
        @(negedge i_clk);
        while (exp_q.size() != 0) @(negedge i_clk);
        @(negedge i_clk);
        check("o_empty", o_empty, 1);
        check("o_busy", o_busy, 0);
    endtask

    task automatic start_test();
        errs_before = errors;
        n_line_wr = 0;
        n_unc_wr = 0;
        n_line_start = 0;
        n_line_end = 0;
        n_unc_start = 0;
        n_unc_end = 0;
    endtask

    task automatic end_test(input string name);
        check("o_line_start pulses", n_line_start, n_line_wr);
        check("o_line_end pulses", n_line_end, n_line_wr);
        check("o_unc_start pulses", n_unc_start, n_unc_wr);
        check("o_unc_end pulses", n_unc_end, n_unc_wr);
        test_num++;
        $display("test %0d %s: %s", test_num, name, (errors == errs_before) ? "ok" : "errors");
    endtask

    // slave with random ready and a 0 to 3 cycle response delay
    always @(posedge i_clk) begin
        logic [31:0] r;
        r = rand32();
        i_awready <= !hold_bus && (heavy ? r[0] : (r[1:0] != 2'b00));
        i_wready <= heavy ? r[4] : (r[5:4] != 2'b00);
        i_bvalid <= 1'b0;
        if (o_wvalid && i_wready && o_wlast) begin
            b_wait = int'(r[9:8]);
            b_pend = 1'b1;
        end
        if (b_pend) begin
            if (b_wait == 0) begin
                i_bvalid <= 1'b1;
                b_pend = 1'b0;
            end else begin
                b_wait--;
            end
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (o_awvalid && i_awready) begin
                cur = '0;
                cur.addr = o_awaddr;
                cur.len = o_awlen;
                beats = 0;
                check("o_awburst", o_awburst, 2'b01);
            end
            if (o_wvalid && i_wready) begin
                if (beats < LINE_WORDS) cur.words[beats] = o_wdata;
                cur.strb = o_wstrb;
                beats++;
                cur.beats = 8'(beats);
            end
            if (i_bvalid && o_bready) obs_q.push_back(cur);
            n_line_start += int'(o_line_start);
            n_line_end += int'(o_line_end);
            n_unc_start += int'(o_unc_start);
            n_unc_end += int'(o_unc_end);
        end
    end

    always @(negedge i_clk) begin
        burst_t obs;
        burst_t want;
        while (obs_q.size() > 0) begin
            obs = obs_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("burst to %h at %0t came with no write pending", obs.addr, $time);
                errors++;
            end else begin
                want = expect_burst(exp_q.pop_front());
                check("o_awaddr", obs.addr, want.addr);
                check("o_awlen", obs.len, want.len);
                check("o_wvalid beats", obs.beats, want.beats);
                check("o_wstrb", obs.strb, want.strb);
                for (int b = 0; b < LINE_WORDS; b++) begin
                    check($sformatf("o_wdata[%0d]", b), obs.words[b], want.words[b]);
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge i_clk);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        repeat (10) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        start_test();
        check("o_awvalid", o_awvalid, 0);
        check("o_wvalid", o_wvalid, 0);
        check("o_wlast", o_wlast, 0);
        check("o_empty", o_empty, 1);
        check("o_busy", o_busy, 0);
        check("o_bready", o_bready, 1);
        check("o_line_slot", o_line_slot, 0);
        check("o_unc_slot", o_unc_slot, 0);
        check("o_line_free", o_line_free, 1);
        end_test("reset values");
        start_test();
        issue(1'b1, 1'b0);
        drain();
        end_test("single line write");
        start_test();
        issue(1'b0, 1'b1);
        drain();
        end_test("single uncached write");
        start_test();
        issue(1'b1, 1'b1);
        mixed(N_MIX);
        drain();
        end_test("arrival order");
        start_test();
        hold_bus = 1'b1;
        for (int i = 0; i < SLOTS; i++) begin
            @(negedge i_clk);
            check("o_line_slot", o_line_slot, i);
            check("o_line_free", o_line_free, 1);
            issue(1'b1, 1'b0);
        end
        for (int i = 0; i < SLOTS - 1; i++) begin
            @(negedge i_clk);
            check("o_unc_slot", o_unc_slot, i);
            check("o_unc_full", o_unc_full, 0);
            issue(1'b0, 1'b1);
        end
        @(negedge i_clk);
        check("o_line_free", o_line_free, 0);
        check("o_unc_full", o_unc_full, 1);
        check("o_busy", o_busy, 1);
        hold_bus = 1'b0;
        drain();
        check("o_line_free", o_line_free, 1);
        check("o_unc_full", o_unc_full, 0);
        check("o_line_slot", o_line_slot, 0);
        check("o_unc_slot", o_unc_slot, 0);
        end_test("slot flags");
        start_test();
        heavy = 1'b1;
        mixed(N_RAND);
        drain();
        heavy = 1'b0;
        end_test("random stalls");
        errors += wbuf_top_inst.u_asserts.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: wbuf_top.f
hw/wbuf_pkg.sv
hw/wbuf_slot_alloc.sv
hw/wbuf_queue.sv
hw/wbuf_line_store.sv
hw/wbuf_beat_counter.sv
hw/wbuf_axi_fsm.sv
hw/wbuf_top.sv
tb/wbuf_asserts.sv
tb/wbuf_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= wbuf_tb
FLIST ?= wbuf_top.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -qx "Test passed" $(LOG); then echo "simulation ok"; \
	else echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
